//--- Bender.yml
package:
  name: masku

sources:
  - design/masku_pkg.sv
  - design/masku_insn_if.sv
  - design/insn_tracker.sv
  - design/mask_merge.sv
  - design/mask_expander.sv
  - design/lane_queue.sv
  - design/masku_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_masku.sv

//--- design/insn_tracker.sv
// ========================================
// Instruction tracker
// Holds one instruction, follows its issue
// phase and pulses done once drained
// ========================================

`timescale 1ns/100ps
`default_nettype none

module insn_tracker (
  input  wire                               clk_i,
  input  wire                               rst_ni,
  input  wire                               req_valid_i,
  output logic                              req_ready_o,
  input  wire  [masku_pkg::VidWidth-1:0]    req_id_i,
  input  wire  [masku_pkg::VlWidth-1:0]     req_vl_i,
  input  wire  [masku_pkg::VaddrWidth-1:0]  req_vd_i,
  input  wire                               req_vm_i,
  input  wire  [masku_pkg::SewWidth-1:0]    req_sew_i,
  input  wire                               req_is_masku_i,
  output logic                              done_o,
  output logic [masku_pkg::VidWidth-1:0]    done_id_o,
  input  wire                               result_empty_i,
  input  wire                               mask_empty_i,
  masku_insn_if.tracker                     insn
);

  logic                              busy_q;
  logic                              issued_q;
  logic [masku_pkg::VidWidth-1:0]    id_q;
  logic [masku_pkg::VlWidth-1:0]     vl_q;
  logic [masku_pkg::VaddrWidth-1:0]  vd_q;
  logic                              vm_q;
  logic [masku_pkg::SewWidth-1:0]    sew_q;
  logic                              is_masku_q;
  logic                              accept;
  logic                              issue_done;
  logic                              queue_empty;

  // One instruction at a time
  assign req_ready_o = !busy_q;
  assign accept      = req_valid_i && !busy_q;

  // Producers only see the instruction until issue is over
  assign insn.valid    = busy_q && !issued_q;
  assign insn.id       = id_q;
  assign insn.vl       = vl_q;
  assign insn.vd       = vd_q;
  assign insn.vm       = vm_q;
  assign insn.sew      = sew_q;
  assign insn.is_masku = is_masku_q;

  // Kind picks the producer and the queue to watch
  assign issue_done  = is_masku_q ? insn.merge_done : insn.expand_done;
  assign queue_empty = is_masku_q ? result_empty_i : mask_empty_i;

  // Done once issue is over and the last beat has left
  assign done_o    = busy_q && issued_q && queue_empty;
  assign done_id_o = id_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      issued_q <= 1'b0;
    end else if (accept) begin
      busy_q   <= 1'b1;
      // Unmasked work for other units has nothing to issue here
      issued_q <= !req_is_masku_i && req_vm_i;
    end else if (done_o) begin
      busy_q   <= 1'b0;
      issued_q <= 1'b0;
    end else if (insn.valid && issue_done) begin
      issued_q <= 1'b1;
    end
  end

  // Instruction fields
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q       <= req_id_i;
      vl_q       <= req_vl_i;
      vd_q       <= req_vd_i;
      vm_q       <= req_vm_i;
      sew_q      <= req_sew_i;
      is_masku_q <= req_is_masku_i;
    end
  end

endmodule

`default_nettype wire

//--- design/lane_queue.sv
// ========================================
// Lane queue
// Small ring with one slot per lane and a
// per-lane accept, for results and masks
// ========================================

`timescale 1ns/100ps
`default_nettype none

module lane_queue #(
  parameter int unsigned EntryWidth = 1,
  parameter int unsigned Depth      = masku_pkg::ResultQueueDepth
) (
  input  wire                                             clk_i,
  input  wire                                             rst_ni,
  input  wire                                             push_i,
  input  wire  [masku_pkg::NrLanes-1:0][EntryWidth-1:0]   data_i,
  output logic                                            full_o,
  output logic                                            empty_o,
  output logic [masku_pkg::NrLanes-1:0]                   valid_o,
  output logic [masku_pkg::NrLanes-1:0][EntryWidth-1:0]   data_o,
  input  wire  [masku_pkg::NrLanes-1:0]                   accept_i
);

  logic [Depth-1:0][masku_pkg::NrLanes-1:0][EntryWidth-1:0]  mem_q;
  logic [Depth-1:0][masku_pkg::NrLanes-1:0]                  valid_q;
  logic [$clog2(Depth)-1:0]                                  wr_ptr_q;
  logic [$clog2(Depth)-1:0]                                  rd_ptr_q;
  logic [$clog2(Depth):0]                                    cnt_q;
  logic [masku_pkg::NrLanes-1:0]                             head_left;
  logic                                                      pop;

  assign full_o  = cnt_q == Depth;
  assign empty_o = cnt_q == '0;

  // Head entry to the lanes
  assign valid_o = valid_q[rd_ptr_q];
  assign data_o  = mem_q[rd_ptr_q];

  // Lanes still waiting on the head
  assign head_left = valid_o & ~accept_i;
  assign pop       = !empty_o && head_left == '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Each lane drops out on its own accept
      valid_q[rd_ptr_q] <= head_left;
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == Depth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push wins over a clear of the same empty slot
      if (push_i) begin
        valid_q[wr_ptr_q] <= '1;
        wr_ptr_q          <= (wr_ptr_q == Depth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + push_i - pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- design/mask_expander.sv
// ========================================
// Mask expander
// Spreads mask bits into per-lane byte
// strobes for masked work on other units
// ========================================

`timescale 1ns/100ps
`default_nettype none

module mask_expander (
  input  wire                                                       clk_i,
  input  wire                                                       rst_ni,
  masku_insn_if.expander                                            insn,
  input  wire  [masku_pkg::NrLanes-1:0][masku_pkg::ElenWidth-1:0]   operand_m_i,
  input  wire  [masku_pkg::NrLanes-1:0]                             operand_m_valid_i,
  output logic [masku_pkg::NrLanes-1:0]                             operand_m_ready_o,
  output logic                                                      push_o,
  output logic [masku_pkg::NrLanes-1:0][masku_pkg::StrbWidth-1:0]   strobe_o,
  input  wire                                                       full_i
);

  // Elements issued so far, base of the current beat
  logic [masku_pkg::VlWidth-1:0]    elem_q;
  // Mask pointer into the current m word
  logic [masku_pkg::VlWidth-1:0]    pnt_q;
  // Elements per beat
  logic [masku_pkg::VlWidth-1:0]    epb;
  logic [masku_pkg::VregWidth-1:0]  m_flat;
  logic                             fire;
  logic                             last;
  logic                             word_end;

  // Eight bytes per register word, shared by the elements
  assign epb = masku_pkg::VlWidth'(masku_pkg::NrLanes * masku_pkg::StrbWidth) >> insn.sew;

  // Lanes side by side as one sequential m word
  assign m_flat = operand_m_i;

  // Only masked instructions for other units
  assign fire = insn.valid && !insn.is_masku && !insn.vm
                && &operand_m_valid_i && !full_i;

  assign last     = elem_q + epb >= insn.vl;
  assign word_end = pnt_q + epb == masku_pkg::VregWidth;

  // Release the m word when used up or when the instruction ends
  assign operand_m_ready_o = {masku_pkg::NrLanes{fire && (word_end || last)}};

  assign push_o           = fire;
  assign insn.expand_done = fire && last;

  always_comb begin : p_strobe
    // Byte j belongs to element j >> sew of the beat
    for (int j = 0; j < masku_pkg::NrLanes * masku_pkg::StrbWidth; j++) begin
      strobe_o[j / masku_pkg::StrbWidth][j % masku_pkg::StrbWidth] =
          (elem_q + (j >> insn.sew) < insn.vl) && m_flat[pnt_q + (j >> insn.sew)];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      elem_q <= '0;
      pnt_q  <= '0;
    end else if (fire) begin
      if (last) begin
        elem_q <= '0;
        pnt_q  <= '0;
      end else begin
        elem_q <= elem_q + epb;
        // Wrap onto the next m word
        pnt_q  <= word_end ? '0 : pnt_q + epb;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/mask_merge.sv
// ========================================
// Mask-logical merge
// Blends ALU result and old destination by
// vl and mask, then queues the words
// ========================================

`timescale 1ns/100ps
`default_nettype none

module mask_merge (
  input  wire                                                         clk_i,
  input  wire                                                         rst_ni,
  masku_insn_if.merge                                                 insn,
  input  wire  [masku_pkg::NrLanes-1:0][masku_pkg::ElenWidth-1:0]     operand_a_i,
  input  wire  [masku_pkg::NrLanes-1:0]                               operand_a_valid_i,
  output logic [masku_pkg::NrLanes-1:0]                               operand_a_ready_o,
  input  wire  [masku_pkg::NrLanes-1:0][masku_pkg::ElenWidth-1:0]     operand_b_i,
  input  wire  [masku_pkg::NrLanes-1:0]                               operand_b_valid_i,
  output logic [masku_pkg::NrLanes-1:0]                               operand_b_ready_o,
  input  wire  [masku_pkg::NrLanes-1:0][masku_pkg::ElenWidth-1:0]     operand_m_i,
  input  wire  [masku_pkg::NrLanes-1:0]                               operand_m_valid_i,
  output logic [masku_pkg::NrLanes-1:0]                               operand_m_ready_o,
  output logic                                                        push_o,
  output logic [masku_pkg::NrLanes-1:0][masku_pkg::ResultWidth-1:0]   entry_o,
  input  wire                                                         full_i
);

  // Beat counter, also the address offset from vd
  logic [masku_pkg::VaddrWidth-1:0]                          beat_q;
  int unsigned                                               base;
  logic                                                      ops_valid;
  logic                                                      fire;
  logic                                                      last;
  logic [masku_pkg::NrLanes-1:0][masku_pkg::ElenWidth-1:0]   wdata;
  logic [masku_pkg::NrLanes-1:0][masku_pkg::StrbWidth-1:0]   be;

  // First register bit index of this beat
  assign base = beat_q * masku_pkg::VregWidth;

  // The m channel is only needed when masked
  assign ops_valid = &operand_a_valid_i && &operand_b_valid_i
                     && (insn.vm || &operand_m_valid_i);
  assign fire      = insn.valid && insn.is_masku && ops_valid && !full_i;

  // This beat's span reaches vl
  assign last = base + masku_pkg::VregWidth >= insn.vl;

  // Take the beat on every lane at once
  assign operand_a_ready_o = {masku_pkg::NrLanes{fire}};
  assign operand_b_ready_o = {masku_pkg::NrLanes{fire}};
  assign operand_m_ready_o = {masku_pkg::NrLanes{fire && !insn.vm}};

  assign push_o          = fire;
  assign insn.merge_done = fire && last;

  always_comb begin : p_merge
    for (int l = 0; l < masku_pkg::NrLanes; l++) begin
      // Bit granular select, a where enabled and b elsewhere
      for (int b = 0; b < masku_pkg::ElenWidth; b++) begin
        if ((base + l * masku_pkg::ElenWidth + b < insn.vl)
            && (insn.vm || operand_m_i[l][b])) begin
          wdata[l][b] = operand_a_i[l][b];
        end else begin
          wdata[l][b] = operand_b_i[l][b];
        end
      end
      // Byte enabled when its first bit is below vl
      for (int s = 0; s < masku_pkg::StrbWidth; s++) begin
        be[l][s] = base + l * masku_pkg::ElenWidth + s * 8 < insn.vl;
      end
      entry_o[l] = {insn.id, insn.vd + beat_q, wdata[l], be[l]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_q <= '0;
    end else if (fire) begin
      // Restart for the next instruction
      beat_q <= last ? '0 : beat_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/masku_insn_if.sv
// ========================================
// Mask unit instruction interface
// Held instruction from the tracker to the
// merge and expander producers
// ========================================

`timescale 1ns/100ps
`default_nettype none

interface masku_insn_if;

  // Instruction in its issue phase
  logic                               valid;
  logic [masku_pkg::VidWidth-1:0]     id;
  logic [masku_pkg::VlWidth-1:0]      vl;
  logic [masku_pkg::VaddrWidth-1:0]   vd;
  logic                               vm;
  logic [masku_pkg::SewWidth-1:0]     sew;
  logic                               is_masku;

  // Issue done, raised with the last pushed beat
  logic                               merge_done;
  logic                               expand_done;

  modport tracker (
    output valid, id, vl, vd, vm, sew, is_masku,
    input  merge_done, expand_done
  );

  modport merge (
    input  valid, id, vl, vd, vm, is_masku,
    output merge_done
  );

  modport expander (
    input  valid, vl, vm, sew, is_masku,
    output expand_done
  );

endinterface

`default_nettype wire

//--- design/masku_pkg.sv
// ========================================
// Mask unit package
// Widths, queue depths and element width
// codes shared by every mask unit block
// ========================================

`default_nettype none

package masku_pkg;

  // Lane geometry
  localparam int unsigned NrLanes   = 2;
  localparam int unsigned ElenWidth = 32;
  localparam int unsigned StrbWidth = ElenWidth / 8;
  // One full register word spans all lanes
  localparam int unsigned VregWidth = NrLanes * ElenWidth;

  // Instruction field widths
  localparam int unsigned VidWidth   = 2;
  localparam int unsigned VaddrWidth = 8;
  // Holds vector lengths up to 128
  localparam int unsigned VlWidth    = 8;
  localparam int unsigned SewWidth   = 2;

  // Element width codes, element bytes are 1 << code
  localparam logic [SewWidth-1:0] Ew8  = 2'd0;
  localparam logic [SewWidth-1:0] Ew16 = 2'd1;
  localparam logic [SewWidth-1:0] Ew32 = 2'd2;

  // Queue depths
  localparam int unsigned MaskQueueDepth   = 2;
  localparam int unsigned ResultQueueDepth = 2;

  // Result entry per lane: id, address, data, byte enable
  localparam int unsigned ResultWidth = VidWidth + VaddrWidth + ElenWidth + StrbWidth;

endpackage

`default_nettype wire

//--- design/masku_top.sv
// ========================================
// Mask unit top level
// Tracker, merge and expander producers and
// the result and mask queues to the lanes
// ========================================

`timescale 1ns/100ps
`default_nettype none

module masku_top (
  input  wire                                                         clk_i,
  input  wire                                                         rst_ni,
  // Sequencer
  input  wire                                                         req_valid_i,
  output logic                                                        req_ready_o,
  input  wire  [masku_pkg::VidWidth-1:0]                              req_id_i,
  input  wire  [masku_pkg::VlWidth-1:0]                               req_vl_i,
  input  wire  [masku_pkg::VaddrWidth-1:0]                            req_vd_i,
  input  wire                                                         req_vm_i,
  input  wire  [masku_pkg::SewWidth-1:0]                              req_sew_i,
  input  wire                                                         req_is_masku_i,
  output logic                                                        done_o,
  output logic [masku_pkg::VidWidth-1:0]                              done_id_o,
  // Operands from the lanes
  input  wire  [masku_pkg::NrLanes-1:0][masku_pkg::ElenWidth-1:0]     operand_a_i,
  input  wire  [masku_pkg::NrLanes-1:0]                               operand_a_valid_i,
  output logic [masku_pkg::NrLanes-1:0]                               operand_a_ready_o,
  input  wire  [masku_pkg::NrLanes-1:0][masku_pkg::ElenWidth-1:0]     operand_b_i,
  input  wire  [masku_pkg::NrLanes-1:0]                               operand_b_valid_i,
  output logic [masku_pkg::NrLanes-1:0]                               operand_b_ready_o,
  input  wire  [masku_pkg::NrLanes-1:0][masku_pkg::ElenWidth-1:0]     operand_m_i,
  input  wire  [masku_pkg::NrLanes-1:0]                               operand_m_valid_i,
  output logic [masku_pkg::NrLanes-1:0]                               operand_m_ready_o,
  // Result writes
  output logic [masku_pkg::NrLanes-1:0]                               result_req_o,
  output logic [masku_pkg::NrLanes-1:0][masku_pkg::VidWidth-1:0]      result_id_o,
  output logic [masku_pkg::NrLanes-1:0][masku_pkg::VaddrWidth-1:0]    result_addr_o,
  output logic [masku_pkg::NrLanes-1:0][masku_pkg::ElenWidth-1:0]     result_wdata_o,
  output logic [masku_pkg::NrLanes-1:0][masku_pkg::StrbWidth-1:0]     result_be_o,
  input  wire  [masku_pkg::NrLanes-1:0]                               result_gnt_i,
  // Byte strobes to the lanes
  output logic [masku_pkg::NrLanes-1:0][masku_pkg::StrbWidth-1:0]     mask_o,
  output logic [masku_pkg::NrLanes-1:0]                               mask_valid_o,
  input  wire  [masku_pkg::NrLanes-1:0]                               mask_ready_i
);

  logic                                                       result_push;
  logic                                                       result_full;
  logic                                                       result_empty;
  logic [masku_pkg::NrLanes-1:0][masku_pkg::ResultWidth-1:0]  result_entry;
  logic [masku_pkg::NrLanes-1:0][masku_pkg::ResultWidth-1:0]  result_head;
  logic                                                       mask_push;
  logic                                                       mask_full;
  logic                                                       mask_empty;
  logic [masku_pkg::NrLanes-1:0][masku_pkg::StrbWidth-1:0]    mask_strobe;
  logic [masku_pkg::NrLanes-1:0]                              merge_m_ready;
  logic [masku_pkg::NrLanes-1:0]                              expand_m_ready;

  masku_insn_if insn_if ();

  insn_tracker insn_tracker_i (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_id_i, .req_vl_i, .req_vd_i,
    .req_vm_i, .req_sew_i, .req_is_masku_i,
    .done_o, .done_id_o,
    .result_empty_i (result_empty),
    .mask_empty_i   (mask_empty),
    .insn           (insn_if.tracker)
  );

  mask_merge mask_merge_i (
    .clk_i, .rst_ni,
    .insn     (insn_if.merge),
    .operand_a_i, .operand_a_valid_i, .operand_a_ready_o,
    .operand_b_i, .operand_b_valid_i, .operand_b_ready_o,
    .operand_m_i, .operand_m_valid_i,
    .operand_m_ready_o (merge_m_ready),
    .push_o   (result_push),
    .entry_o  (result_entry),
    .full_i   (result_full)
  );

  mask_expander mask_expander_i (
    .clk_i, .rst_ni,
    .insn              (insn_if.expander),
    .operand_m_i, .operand_m_valid_i,
    .operand_m_ready_o (expand_m_ready),
    .push_o            (mask_push),
    .strobe_o          (mask_strobe),
    .full_i            (mask_full)
  );

  // Only one producer runs at a time, so the m readies merge
  assign operand_m_ready_o = merge_m_ready | expand_m_ready;

  lane_queue #(
    .EntryWidth (masku_pkg::ResultWidth),
    .Depth      (masku_pkg::ResultQueueDepth)
  ) result_queue_i (
    .clk_i, .rst_ni,
    .push_i   (result_push),
    .data_i   (result_entry),
    .full_o   (result_full),
    .empty_o  (result_empty),
    .valid_o  (result_req_o),
    .data_o   (result_head),
    .accept_i (result_gnt_i)
  );

  lane_queue #(
    .EntryWidth (masku_pkg::StrbWidth),
    .Depth      (masku_pkg::MaskQueueDepth)
  ) mask_queue_i (
    .clk_i, .rst_ni,
    .push_i   (mask_push),
    .data_i   (mask_strobe),
    .full_o   (mask_full),
    .empty_o  (mask_empty),
    .valid_o  (mask_valid_o),
    .data_o   (mask_o),
    .accept_i (mask_ready_i)
  );

  // Split each head entry into the lane write fields
  for (genvar l = 0; l < masku_pkg::NrLanes; l++) begin : gen_result_fields
    assign {result_id_o[l], result_addr_o[l], result_wdata_o[l], result_be_o[l]} =
        result_head[l];
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+tests
design/masku_pkg.sv
design/masku_insn_if.sv
design/insn_tracker.sv
design/mask_merge.sv
design/mask_expander.sv
design/lane_queue.sv
design/masku_top.sv
tests/tb_masku.sv

//--- tests/tb_masku_model.svh
// ========================================
// Mask unit reference model
// Expected merged words, byte enables and
// per-lane strobes
// ========================================

`ifndef TB_MASKU_MODEL_SVH
`define TB_MASKU_MODEL_SVH

// Bit i of beat k is a below vl where m allows it, b elsewhere
function automatic logic [31:0] merged_word(input logic [31:0] a, input logic [31:0] b,
                                            input logic [31:0] m, input int vl,
                                            input logic vm, input int k, input int l);
  logic [31:0] w;
  int          i;
  for (int bt = 0; bt < 32; bt++) begin
    i = k * 64 + l * 32 + bt;
    w[bt] = ((i < vl) && (vm || m[bt])) ? a[bt] : b[bt];
  end
  return w;
endfunction

// Byte on when its first bit is below vl
function automatic logic [3:0] byte_enable(input int vl, input int k, input int l);
  logic [3:0] be;
  for (int s = 0; s < 4; s++) be[s] = (k * 64 + l * 32 + s * 8) < vl;
  return be;
endfunction

// Strobes of lane l in expansion beat t
function automatic logic [3:0] lane_strobe(input logic [63:0] m, input int vl,
                                           input int sew, input int t, input int l);
  logic [3:0] st;
  int         ebytes;
  int         e;
  ebytes = 1 << sew;
  for (int s = 0; s < 4; s++) begin
    e = t * (8 / ebytes) + (l * 4 + s) / ebytes;
    st[s] = (e < vl) && m[e % 64];
  end
  return st;
endfunction

`endif

//--- tests/tb_masku.sv
// ========================================
// Mask unit testbench
// Random instructions, lane responders and
// checks against the reference model
// ========================================

`timescale 1ns/100ps
`default_nettype none

module tb_masku;

  localparam int NumInsns = 60;
  localparam int Timeout  = 2000;
  localparam int N        = masku_pkg::NrLanes;
  localparam int RW       = masku_pkg::ResultWidth;
  localparam int SW       = masku_pkg::StrbWidth;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic req_valid_i, req_ready_o, req_vm_i, req_is_masku_i, done_o;
  logic [masku_pkg::VidWidth-1:0]   req_id_i, done_id_o;
  logic [masku_pkg::VlWidth-1:0]    req_vl_i;
  logic [masku_pkg::VaddrWidth-1:0] req_vd_i;
  logic [masku_pkg::SewWidth-1:0]   req_sew_i;
  logic [N-1:0][masku_pkg::ElenWidth-1:0] operand_a_i, operand_b_i, operand_m_i;
  logic [N-1:0] operand_a_valid_i, operand_b_valid_i, operand_m_valid_i;
  logic [N-1:0] operand_a_ready_o, operand_b_ready_o, operand_m_ready_o;
  logic [N-1:0] result_req_o, result_gnt_i, mask_valid_o, mask_ready_i;
  logic [N-1:0][masku_pkg::VidWidth-1:0]   result_id_o;
  logic [N-1:0][masku_pkg::VaddrWidth-1:0] result_addr_o;
  logic [N-1:0][masku_pkg::ElenWidth-1:0]  result_wdata_o;
  logic [N-1:0][SW-1:0] result_be_o, mask_o;

  // Channel index 0 is a, 1 is b and 2 is m
  logic [N-1:0][masku_pkg::ElenWidth-1:0] words [3][2];
  logic [N-1:0] vld [3];
  wire  [N-1:0] rdy [3];
  int ptr [3], cnt [3], need [3], start [3];
  // Expected entries per lane with separate read pointers
  logic [RW-1:0] exp_res [N][1024];
  logic [SW-1:0] exp_msk [N][1024];
  int res_wr, msk_wr, res_rd [N], msk_rd [N];
  int mismatches, other_errors;
  logic [31:0] lfsr;
  logic accepted;
  logic [masku_pkg::VidWidth-1:0] cur_id;
  logic cur_is_masku;

  assign rdy[0] = operand_a_ready_o;
  assign rdy[1] = operand_b_ready_o;
  assign rdy[2] = operand_m_ready_o;

  masku_top dut_i (.*);

  initial begin
    forever #2 clk_i = ~clk_i;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic check_result(input string name, input logic [RW-1:0] exp,
                              input logic [RW-1:0] act);
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      mismatches++;
    end
  endtask

  task automatic check_mask(input string name, input logic [SW-1:0] exp,
                            input logic [SW-1:0] act);
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      mismatches++;
    end
  endtask

  task automatic check_id(input string name, input logic [masku_pkg::VidWidth-1:0] exp,
                          input logic [masku_pkg::VidWidth-1:0] act);
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      mismatches++;
    end
  endtask

  task automatic report_error(input string what);
    $display("Error at %0t: %s", $time, what);
    other_errors++;
  endtask

  `include "tb_masku_model.svh"

  // Operand sources and lane responders drive on the falling edge
  always @(negedge clk_i) begin
    for (int c = 0; c < 3; c++) begin
      if (cnt[c] != ptr[c]) begin
        ptr[c] = cnt[c];
        vld[c] = '0;
      end
      // Valids show up late and lane by lane
      for (int l = 0; l < N; l++) begin
        if (ptr[c] < need[c] && !vld[c][l] && take_bits(1)) vld[c][l] = 1'b1;
      end
    end
    operand_a_i = words[0][(ptr[0] - start[0]) & 1];
    operand_b_i = words[1][(ptr[1] - start[1]) & 1];
    operand_m_i = words[2][(ptr[2] - start[2]) & 1];
    operand_a_valid_i = vld[0];
    operand_b_valid_i = vld[1];
    operand_m_valid_i = vld[2];
    for (int l = 0; l < N; l++) begin
      result_gnt_i[l] = result_req_o[l] && take_bits(2) == 2'd0;
      mask_ready_i[l] = mask_valid_o[l] && take_bits(2) != 2'd0;
    end
  end

  // Monitor on the rising edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      for (int c = 0; c < 3; c++) begin
        if ((rdy[c] & ~vld[c]) != '0) report_error("operand ready without valid");
        if (rdy[c] != '0 && rdy[c] != '1) report_error("operand ready on some lanes only");
        if (rdy[c] != '0) cnt[c] <= cnt[c] + 1;
      end
      for (int l = 0; l < N; l++) begin
        if (result_req_o[l] && result_gnt_i[l]) begin
          if (res_rd[l] >= res_wr) begin
            report_error("result granted with none expected");
          end else begin
            check_result($sformatf("result lane %0d", l), exp_res[l][res_rd[l]],
                         {result_id_o[l], result_addr_o[l], result_wdata_o[l],
                          result_be_o[l]});
            res_rd[l]++;
          end
        end
        if (mask_valid_o[l] && mask_ready_i[l]) begin
          if (msk_rd[l] >= msk_wr) begin
            report_error("mask taken with none expected");
          end else begin
            check_mask($sformatf("mask_o[%0d]", l), exp_msk[l][msk_rd[l]], mask_o[l]);
            msk_rd[l]++;
          end
        end
      end
      if (accepted && req_ready_o) report_error("req_ready_o high while busy");
      if (done_o) begin
        if (!accepted) begin
          report_error("done pulse with no instruction outstanding");
        end else begin
          check_id("done_id_o", cur_id, done_id_o);
          for (int l = 0; l < N; l++) begin
            if (cur_is_masku ? res_rd[l] != res_wr : msk_rd[l] != msk_wr)
              report_error("done before every word was taken");
          end
          for (int c = 0; c < 3; c++) begin
            if (cnt[c] != need[c]) report_error("done before every operand beat was taken");
          end
        end
        accepted <= 1'b0;
      end else if (req_valid_i && req_ready_o) begin
        accepted <= 1'b1;
      end
    end
  end

  initial begin
    int nb, epb, tries;
    logic timed_out;
    lfsr = 32'h5433a59f;
    rst_ni = 1'b0;
    {req_valid_i, req_vm_i, req_is_masku_i, req_id_i, req_vl_i, req_vd_i, req_sew_i} = '0;
    {operand_a_i, operand_b_i, operand_m_i} = '0;
    {operand_a_valid_i, operand_b_valid_i, operand_m_valid_i} = '0;
    result_gnt_i = '0;
    mask_ready_i = '0;
    accepted = 1'b0;
    timed_out = 1'b0;
    {res_wr, msk_wr, mismatches, other_errors} = '0;
    for (int c = 0; c < 3; c++) begin
      {ptr[c], cnt[c], need[c], start[c]} = '0;
      vld[c] = '0;
    end
    for (int l = 0; l < N; l++) begin
      res_rd[l] = 0;
      msk_rd[l] = 0;
    end
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    if (done_o || operand_a_ready_o || operand_b_ready_o || operand_m_ready_o
        || result_req_o || mask_valid_o || !req_ready_o)
      report_error("control outputs active after reset");

    for (int n = 0; n < NumInsns && !timed_out; n++) begin
      tries = 0;
      while (!req_ready_o && tries < Timeout) begin
        @(negedge clk_i);
        tries++;
      end
      if (tries >= Timeout) begin
        report_error("timeout waiting for req_ready_o");
        timed_out = 1'b1;
        break;
      end
      req_is_masku_i = take_bits(1);
      req_vm_i       = take_bits(1);
      req_sew_i      = take_bits(2);
      if (req_sew_i == 2'd3) req_sew_i = masku_pkg::Ew32;
      req_vl_i = take_bits(7) + 1;
      req_vd_i = take_bits(8);
      req_id_i = take_bits(2);
      cur_id = req_id_i;
      cur_is_masku = req_is_masku_i;
      for (int c = 0; c < 3; c++) begin
        for (int k = 0; k < 2; k++) words[c][k] = {take_bits(32), take_bits(32)};
        start[c] = need[c];
      end
      nb = (req_vl_i + 63) / 64;
      if (req_is_masku_i) begin
        need[0] += nb;
        need[1] += nb;
        if (!req_vm_i) need[2] += nb;
        for (int k = 0; k < nb; k++) begin
          for (int l = 0; l < N; l++) begin
            exp_res[l][res_wr] = {req_id_i, req_vd_i + 8'(k),
                merged_word(words[0][k][l], words[1][k][l], words[2][k][l],
                            req_vl_i, req_vm_i, k, l),
                byte_enable(req_vl_i, k, l)};
          end
          res_wr++;
        end
      end else if (!req_vm_i) begin
        need[2] += nb;
        epb = 8 >> req_sew_i;
        for (int t = 0; t < (req_vl_i + epb - 1) / epb; t++) begin
          for (int l = 0; l < N; l++) begin
            exp_msk[l][msk_wr] = lane_strobe(words[2][(t * epb) / 64], req_vl_i,
                                             req_sew_i, t, l);
          end
          msk_wr++;
        end
      end
      req_valid_i = 1'b1;
      @(negedge clk_i);
      req_valid_i = 1'b0;
      // Wait for the done pulse to clear the accepted flag
      tries = 0;
      while (accepted && tries < Timeout) begin
        @(negedge clk_i);
        tries++;
      end
      if (tries >= Timeout) begin
        report_error("timeout waiting for done_o");
        timed_out = 1'b1;
      end
    end

    repeat (4) @(negedge clk_i);
    for (int l = 0; l < N; l++) begin
      if (res_rd[l] != res_wr || msk_rd[l] != msk_wr)
        report_error("expected words never arrived");
    end
    $display("Checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
